// ==== hw/alu_imm_ldu_iq.sv ====
`timescale 1ns/1ps

// issue queue for the ALU reg-imm and LDU pipelines
// entries kept oldest first in a compacting array
// operand A woken by the banked writeback bus
// one oldest-ready op issued per pipeline per cycle

module alu_imm_ldu_iq #(
	parameter int IQ_ENTRIES = 8
) (
	input logic CLK,
	input logic nRST,

	// dispatch from rename
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input iq_types_pkg::iq_dispatch_t [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_by_way,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] dispatch_ack_by_way,

	// pipeline feedback
	input logic alu_imm_pipeline_ready,
	input logic ldu_pipeline_ready,

	// writeback tags by bank
	input iq_types_pkg::iq_wb_bus_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_bus_by_bank,

	// issue and register read
	output iq_types_pkg::iq_issue_t issue_alu_imm,
	output iq_types_pkg::iq_issue_t issue_ldu,
	output iq_types_pkg::iq_prf_req_t prf_alu_imm_req,
	output iq_types_pkg::iq_prf_req_t prf_ldu_req
);

	import core_types_pkg::*;
	import iq_types_pkg::*;

	localparam int COUNT_W = $clog2(IQ_ENTRIES+1);
	localparam int IDX_W = $clog2(IQ_ENTRIES);
	localparam int WAY_COUNT_W = $clog2(DISPATCH_WAYS+1);

	// entry array
	logic [IQ_ENTRIES-1:0] valid_by_entry;
	iq_dispatch_t [IQ_ENTRIES-1:0] entry_by_entry;
	logic [IQ_ENTRIES-1:0] next_valid_by_entry;
	iq_dispatch_t [IQ_ENTRIES-1:0] next_entry_by_entry;

	logic [COUNT_W-1:0] occupied_count;
	logic [COUNT_W-1:0] survivor_count;
	logic [WAY_COUNT_W-1:0] append_count;
	logic [COUNT_W:0] next_occupied_count;

	// wakeup and select
	logic [IQ_ENTRIES-1:0] woken_by_entry;
	logic [IQ_ENTRIES-1:0] A_avail_by_entry;
	logic [IQ_ENTRIES-1:0] alu_imm_candidate_by_entry;
	logic [IQ_ENTRIES-1:0] ldu_candidate_by_entry;
	logic [IQ_ENTRIES-1:0] alu_imm_select_onehot;
	logic [IQ_ENTRIES-1:0] ldu_select_onehot;
	logic alu_imm_select_valid;
	logic ldu_select_valid;
	iq_dispatch_t alu_imm_entry;
	iq_dispatch_t ldu_entry;
	logic alu_imm_woken;
	logic ldu_woken;

	function automatic iq_issue_t make_issue(
		input logic valid,
		input iq_dispatch_t entry,
		input logic woken
	);
		iq_issue_t issue;
		issue.valid = valid;
		issue.op = entry.op;
		issue.imm12 = entry.imm12;
		// value arrives on the bypass this cycle
		issue.A_forward = woken && !entry.A_ready;
		issue.A_is_zero = entry.A_is_zero;
		issue.A_bank = entry.A_PR[LOG_PRF_BANK_COUNT-1:0];
		issue.dest_PR = entry.dest_PR;
		issue.ROB_index = entry.ROB_index;
		return issue;
	endfunction

	function automatic iq_prf_req_t make_prf_req(
		input iq_issue_t issue,
		input logic [LOG_PR_COUNT-1:0] A_PR
	);
		iq_prf_req_t req;
		// no read for a forwarded or hardwired zero operand
		req.valid = issue.valid && !issue.A_forward && !issue.A_is_zero;
		req.A_PR = A_PR;
		return req;
	endfunction

	// ----------------------------------------
	// dispatch
	// ----------------------------------------

	always_comb begin
		occupied_count = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			occupied_count = occupied_count + COUNT_W'(valid_by_entry[i]);
		end
	end

	iq_dispatch_alloc #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) dispatch_alloc (
		.attempt_by_way(dispatch_attempt_by_way),
		.occupied_count(occupied_count),
		.ack_by_way(dispatch_ack_by_way),
		.append_count(append_count)
	);

	// ----------------------------------------
	// wakeup and select
	// ----------------------------------------

	// match against the slot of the operand's own bank
	always_comb begin
		iq_wb_bus_t wb;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			wb = wb_bus_by_bank[entry_by_entry[i].A_PR[LOG_PRF_BANK_COUNT-1:0]];
			woken_by_entry[i] = wb.valid
				&& (wb.upper_PR == entry_by_entry[i].A_PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
			A_avail_by_entry[i] = entry_by_entry[i].A_ready || entry_by_entry[i].A_is_zero
				|| woken_by_entry[i];
			alu_imm_candidate_by_entry[i] = valid_by_entry[i] && entry_by_entry[i].valid_alu_imm
				&& A_avail_by_entry[i];
			ldu_candidate_by_entry[i] = valid_by_entry[i] && entry_by_entry[i].valid_ldu
				&& A_avail_by_entry[i];
		end
	end

	iq_oldest_select #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) alu_imm_select (
		.candidate_by_entry(alu_imm_candidate_by_entry),
		.pipeline_ready(alu_imm_pipeline_ready),
		.select_onehot(alu_imm_select_onehot),
		.select_valid(alu_imm_select_valid)
	);

	iq_oldest_select #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) ldu_select (
		.candidate_by_entry(ldu_candidate_by_entry),
		.pipeline_ready(ldu_pipeline_ready),
		.select_onehot(ldu_select_onehot),
		.select_valid(ldu_select_valid)
	);

	// one-hot read of the picked entries
	always_comb begin
		alu_imm_entry = '0;
		alu_imm_woken = 1'b0;
		ldu_entry = '0;
		ldu_woken = 1'b0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (alu_imm_select_onehot[i]) begin
				alu_imm_entry = entry_by_entry[i];
				alu_imm_woken = woken_by_entry[i];
			end
			if (ldu_select_onehot[i]) begin
				ldu_entry = entry_by_entry[i];
				ldu_woken = woken_by_entry[i];
			end
		end
	end

	assign issue_alu_imm = make_issue(alu_imm_select_valid, alu_imm_entry, alu_imm_woken);
	assign issue_ldu = make_issue(ldu_select_valid, ldu_entry, ldu_woken);
	assign prf_alu_imm_req = make_prf_req(issue_alu_imm, alu_imm_entry.A_PR);
	assign prf_ldu_req = make_prf_req(issue_ldu, ldu_entry.A_PR);

	// ----------------------------------------
	// compaction and fill
	// ----------------------------------------

	// survivors slide down in age order, acked ways append behind them
	always_comb begin
		logic [COUNT_W-1:0] fill;
		next_entry_by_entry = entry_by_entry;
		fill = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (valid_by_entry[i] && !alu_imm_select_onehot[i] && !ldu_select_onehot[i]) begin
				next_entry_by_entry[fill[IDX_W-1:0]] = entry_by_entry[i];
				next_entry_by_entry[fill[IDX_W-1:0]].A_ready = entry_by_entry[i].A_ready
					|| woken_by_entry[i];
				fill = fill + COUNT_W'(1);
			end
		end
		survivor_count = fill;
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			if (dispatch_ack_by_way[w] && (fill < COUNT_W'(IQ_ENTRIES))) begin
				next_entry_by_entry[fill[IDX_W-1:0]] = dispatch_by_way[w];
				fill = fill + COUNT_W'(1);
			end
		end
	end

	assign next_occupied_count = {1'b0, survivor_count} + (COUNT_W+1)'(append_count);

	// valid bits stay a contiguous run from entry 0
	always_comb begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			next_valid_by_entry[i] = (COUNT_W+1)'(i) < next_occupied_count;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_by_entry <= '0;
		end else begin
			valid_by_entry <= next_valid_by_entry;
		end
	end

	always_ff @(posedge CLK) begin
		entry_by_entry <= next_entry_by_entry;
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// rename steers each attempting op to exactly one pipeline
	for (genvar w = 0; w < DISPATCH_WAYS; w++) begin : g_way_check
		assert property (@(posedge CLK) disable iff (!nRST)
			dispatch_attempt_by_way[w]
				|-> (dispatch_by_way[w].valid_alu_imm ^ dispatch_by_way[w].valid_ldu))
			else $error("dispatch way %0d attempts without exactly one pipeline", w);
	end

	assert property (@(posedge CLK) disable iff (!nRST)
		(alu_imm_select_onehot & ldu_select_onehot) == '0)
		else $error("both pipelines picked the same entry");

	assert property (@(posedge CLK) disable iff (!nRST)
		next_occupied_count <= (COUNT_W+1)'(IQ_ENTRIES))
		else $error("queue occupancy would exceed its entries");

endmodule

// ==== hw/alu_imm_ldu_iq_wrapper.sv ====
`timescale 1ns/1ps

// pipeline-boundary wrapper for the ALU reg-imm / LDU issue queue
// one reset-cleared register stage on every input and every output

module alu_imm_ldu_iq_wrapper #(
	parameter int IQ_ENTRIES = 8
) (
	input logic CLK,
	input logic nRST,

	// dispatch from rename
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] next_dispatch_attempt_by_way,
	input iq_types_pkg::iq_dispatch_t [core_types_pkg::DISPATCH_WAYS-1:0] next_dispatch_by_way,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] last_dispatch_ack_by_way,

	// pipeline feedback
	input logic next_alu_imm_pipeline_ready,
	input logic next_ldu_pipeline_ready,

	// writeback tags by bank
	input iq_types_pkg::iq_wb_bus_t [core_types_pkg::PRF_BANK_COUNT-1:0] next_wb_bus_by_bank,

	// issue and register read
	output iq_types_pkg::iq_issue_t last_issue_alu_imm,
	output iq_types_pkg::iq_issue_t last_issue_ldu,
	output iq_types_pkg::iq_prf_req_t last_prf_alu_imm_req,
	output iq_types_pkg::iq_prf_req_t last_prf_ldu_req
);

	import core_types_pkg::*;
	import iq_types_pkg::*;

	// queue side of the register stages
	logic [DISPATCH_WAYS-1:0] dispatch_attempt_by_way;
	iq_dispatch_t [DISPATCH_WAYS-1:0] dispatch_by_way;
	logic [DISPATCH_WAYS-1:0] dispatch_ack_by_way;
	logic alu_imm_pipeline_ready;
	logic ldu_pipeline_ready;
	iq_wb_bus_t [PRF_BANK_COUNT-1:0] wb_bus_by_bank;
	iq_issue_t issue_alu_imm;
	iq_issue_t issue_ldu;
	iq_prf_req_t prf_alu_imm_req;
	iq_prf_req_t prf_ldu_req;

	alu_imm_ldu_iq #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) queue (
		.CLK(CLK),
		.nRST(nRST),
		.dispatch_attempt_by_way(dispatch_attempt_by_way),
		.dispatch_by_way(dispatch_by_way),
		.dispatch_ack_by_way(dispatch_ack_by_way),
		.alu_imm_pipeline_ready(alu_imm_pipeline_ready),
		.ldu_pipeline_ready(ldu_pipeline_ready),
		.wb_bus_by_bank(wb_bus_by_bank),
		.issue_alu_imm(issue_alu_imm),
		.issue_ldu(issue_ldu),
		.prf_alu_imm_req(prf_alu_imm_req),
		.prf_ldu_req(prf_ldu_req)
	);

	// ----------------------------------------
	// input stage
	// ----------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			dispatch_attempt_by_way <= '0;
			dispatch_by_way <= '0;
			alu_imm_pipeline_ready <= 1'b0;
			ldu_pipeline_ready <= 1'b0;
			wb_bus_by_bank <= '0;
		end else begin
			dispatch_attempt_by_way <= next_dispatch_attempt_by_way;
			dispatch_by_way <= next_dispatch_by_way;
			alu_imm_pipeline_ready <= next_alu_imm_pipeline_ready;
			ldu_pipeline_ready <= next_ldu_pipeline_ready;
			wb_bus_by_bank <= next_wb_bus_by_bank;
		end
	end

	// ----------------------------------------
	// output stage
	// ----------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			last_dispatch_ack_by_way <= '0;
			last_issue_alu_imm <= '0;
			last_issue_ldu <= '0;
			last_prf_alu_imm_req <= '0;
			last_prf_ldu_req <= '0;
		end else begin
			last_dispatch_ack_by_way <= dispatch_ack_by_way;
			last_issue_alu_imm <= issue_alu_imm;
			last_issue_ldu <= issue_ldu;
			last_prf_alu_imm_req <= prf_alu_imm_req;
			last_prf_ldu_req <= prf_ldu_req;
		end
	end

endmodule

// ==== hw/core_types_pkg.sv ====
// core-wide sizing constants
// physical register tags, register file banking, reorder buffer and dispatch width

package core_types_pkg;

	// ----------------------------------------
	// physical register file
	// ----------------------------------------

	// tag width of a physical register
	localparam int LOG_PR_COUNT = 7;

	// register file split by the low tag bits
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;

	// ----------------------------------------
	// reorder buffer and dispatch
	// ----------------------------------------

	// index into the reorder buffer
	localparam int LOG_ROB_ENTRIES = 7;

	// ops handed over by rename each cycle
	localparam int DISPATCH_WAYS = 4;

endpackage

// ==== hw/iq_dispatch_alloc.sv ====
`timescale 1ns/1ps

// dispatch acknowledge for the issue queue
// acks attempting ways lowest index first while free entries remain

module iq_dispatch_alloc #(
	parameter int IQ_ENTRIES = 8
) (
	input logic [core_types_pkg::DISPATCH_WAYS-1:0] attempt_by_way,
	input logic [$clog2(IQ_ENTRIES+1)-1:0] occupied_count,
	output logic [core_types_pkg::DISPATCH_WAYS-1:0] ack_by_way,
	output logic [$clog2(core_types_pkg::DISPATCH_WAYS+1)-1:0] append_count
);

	import core_types_pkg::*;

	localparam int COUNT_W = $clog2(IQ_ENTRIES+1);
	localparam int WAY_COUNT_W = $clog2(DISPATCH_WAYS+1);
	// wide enough for either count
	localparam int CMP_W = (COUNT_W > WAY_COUNT_W) ? COUNT_W : WAY_COUNT_W;

	logic [CMP_W-1:0] free_count;
	logic [DISPATCH_WAYS-1:0][CMP_W-1:0] prefix_count_by_way;

	// free entries as of the cycle start
	// entries issued this cycle are not reused until the next one
	assign free_count = CMP_W'(IQ_ENTRIES) - CMP_W'(occupied_count);

	// running count of attempts up to and including each way
	always_comb begin
		logic [CMP_W-1:0] running;
		running = '0;
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			running = running + CMP_W'(attempt_by_way[w]);
			prefix_count_by_way[w] = running;
		end
	end

	always_comb begin
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			ack_by_way[w] = attempt_by_way[w] && (prefix_count_by_way[w] <= free_count);
		end
	end

	// ops appended at the end of the cycle
	always_comb begin
		append_count = '0;
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			append_count = append_count + WAY_COUNT_W'(ack_by_way[w]);
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// acked ways are the attempting ways below some cutoff
	always_comb begin
		logic gap_seen;
		logic prefix_ok;
		gap_seen = 1'b0;
		prefix_ok = 1'b1;
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			if (ack_by_way[w] && (gap_seen || !attempt_by_way[w])) begin
				prefix_ok = 1'b0;
			end
			if (attempt_by_way[w] && !ack_by_way[w]) begin
				gap_seen = 1'b1;
			end
		end
		assert (prefix_ok)
			else $error("dispatch acks are not an in-order prefix of the attempts");
	end

endmodule

// ==== hw/iq_oldest_select.sv ====
`timescale 1ns/1ps

// oldest-ready picker for one pipeline
// lowest candidate index wins, output one-hot

module iq_oldest_select #(
	parameter int IQ_ENTRIES = 8
) (
	input logic [IQ_ENTRIES-1:0] candidate_by_entry,
	input logic pipeline_ready,
	output logic [IQ_ENTRIES-1:0] select_onehot,
	output logic select_valid
);

	// entry 0 holds the oldest op
	always_comb begin
		logic found;
		found = 1'b0;
		select_onehot = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (pipeline_ready && candidate_by_entry[i] && !found) begin
				select_onehot[i] = 1'b1;
				found = 1'b1;
			end
		end
	end

	assign select_valid = pipeline_ready && (|candidate_by_entry);

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// at most one pick, always a candidate, and flagged by select_valid
	always_comb begin
		assert ($onehot0(select_onehot)
			&& ((select_onehot & ~candidate_by_entry) == '0)
			&& (select_valid == (|select_onehot)))
			else $error("oldest select produced a bad pick");
	end

endmodule

// ==== hw/iq_types_pkg.sv ====
// issue queue traffic
// dispatch payloads, banked writeback tags, issue payloads and register reads

package iq_types_pkg;

	import core_types_pkg::*;

	// ----------------------------------------
	// inbound
	// ----------------------------------------

	// one dispatch way from rename, also the stored entry format
	typedef struct packed {
		logic valid_alu_imm;
		logic valid_ldu;
		logic [3:0] op;
		logic [11:0] imm12;
		logic [LOG_PR_COUNT-1:0] A_PR;
		logic A_ready;
		logic A_is_zero;
		logic [LOG_PR_COUNT-1:0] dest_PR;
		logic [LOG_ROB_ENTRIES-1:0] ROB_index;
	} iq_dispatch_t;

	// one bank's writeback slot, bank bits implied by position
	typedef struct packed {
		logic valid;
		logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_PR;
	} iq_wb_bus_t;

	// ----------------------------------------
	// outbound
	// ----------------------------------------

	// op handed to a pipeline
	typedef struct packed {
		logic valid;
		logic [3:0] op;
		logic [11:0] imm12;
		logic A_forward;
		logic A_is_zero;
		logic [LOG_PRF_BANK_COUNT-1:0] A_bank;
		logic [LOG_PR_COUNT-1:0] dest_PR;
		logic [LOG_ROB_ENTRIES-1:0] ROB_index;
	} iq_issue_t;

	// operand A read from the register file
	typedef struct packed {
		logic valid;
		logic [LOG_PR_COUNT-1:0] A_PR;
	} iq_prf_req_t;

endpackage

// ==== lorof_iq.f ====
+incdir+tests
hw/core_types_pkg.sv
hw/iq_types_pkg.sv
hw/iq_dispatch_alloc.sv
hw/iq_oldest_select.sv
hw/alu_imm_ldu_iq.sv
hw/alu_imm_ldu_iq_wrapper.sv
tests/tb_alu_imm_ldu_iq.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the issue queue testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
	-f lorof_iq.f \
	--top-module tb_alu_imm_ldu_iq \
	--Mdir "$BUILD_DIR" \
	-o tb_alu_imm_ldu_iq

"./$BUILD_DIR/tb_alu_imm_ldu_iq" 2>&1 | tee "$LOG_FILE"

if grep -q "^TEST RESULT: PASS$" "$LOG_FILE"; then
	echo "simulation passed"
else
	echo "simulation failed, see $LOG_FILE"
	exit 1
fi

// ==== tests/tb_iq_model.svh ====
`ifndef TB_IQ_MODEL_SVH
`define TB_IQ_MODEL_SVH

// reference issue queue and random source for the testbench
// included inside the testbench module, follows the queue one cycle behind the ports

logic [31:0] rng_state = 32'd80778;

// queue contents, oldest first
iq_dispatch_t model_q[$];

// inputs as the queue sees them after the wrapper's input stage
logic [DISPATCH_WAYS-1:0] seen_attempt;
iq_dispatch_t [DISPATCH_WAYS-1:0] seen_dispatch;
logic seen_alu_imm_ready;
logic seen_ldu_ready;
iq_wb_bus_t [PRF_BANK_COUNT-1:0] seen_wb;

// predicted port values
logic [DISPATCH_WAYS-1:0] exp_ack;
iq_issue_t exp_alu_imm;
iq_issue_t exp_ldu;
iq_prf_req_t exp_alu_imm_req;
iq_prf_req_t exp_ldu_req;

function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// writeback slot of the operand's bank carries its upper tag bits
function automatic logic operand_woken(input iq_dispatch_t e);
	iq_wb_bus_t slot;
	slot = seen_wb[e.A_PR[LOG_PRF_BANK_COUNT-1:0]];
	return slot.valid && (slot.upper_PR == e.A_PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
endfunction

function automatic iq_issue_t predict_issue(input int pick);
	iq_issue_t p;
	iq_dispatch_t e;
	p = '0;
	if (pick >= 0) begin
		e = model_q[pick];
		p.valid = 1'b1;
		p.op = e.op;
		p.imm12 = e.imm12;
		p.A_forward = operand_woken(e) && !e.A_ready;
		p.A_is_zero = e.A_is_zero;
		p.A_bank = e.A_PR[LOG_PRF_BANK_COUNT-1:0];
		p.dest_PR = e.dest_PR;
		p.ROB_index = e.ROB_index;
	end
	return p;
endfunction

function automatic iq_prf_req_t predict_req(input int pick, input iq_issue_t p);
	iq_prf_req_t req;
	req = '0;
	if (pick >= 0) begin
		req.valid = !p.A_forward && !p.A_is_zero;
		req.A_PR = model_q[pick].A_PR;
	end
	return req;
endfunction

task automatic reset_model();
	model_q.delete();
	seen_attempt = '0;
	seen_dispatch = '0;
	seen_alu_imm_ready = 1'b0;
	seen_ldu_ready = 1'b0;
	seen_wb = '0;
	exp_ack = '0;
	exp_alu_imm = '0;
	exp_ldu = '0;
	exp_alu_imm_req = '0;
	exp_ldu_req = '0;
endtask

// one queue cycle: acks, picks, then the next contents
task automatic step_model();
	int free_count;
	int attempts;
	int alu_pick;
	int ldu_pick;
	iq_dispatch_t e;
	iq_dispatch_t kept[$];
	free_count = IQ_ENTRIES - model_q.size();
	attempts = 0;
	for (int w = 0; w < DISPATCH_WAYS; w++) begin
		if (seen_attempt[w]) begin
			attempts++;
		end
		exp_ack[w] = seen_attempt[w] && (attempts <= free_count);
	end
	alu_pick = -1;
	ldu_pick = -1;
	for (int i = 0; i < model_q.size(); i++) begin
		e = model_q[i];
		if (e.A_ready || e.A_is_zero || operand_woken(e)) begin
			if (e.valid_alu_imm && seen_alu_imm_ready && (alu_pick < 0)) begin
				alu_pick = i;
			end
			if (e.valid_ldu && seen_ldu_ready && (ldu_pick < 0)) begin
				ldu_pick = i;
			end
		end
	end
	exp_alu_imm = predict_issue(alu_pick);
	exp_ldu = predict_issue(ldu_pick);
	exp_alu_imm_req = predict_req(alu_pick, exp_alu_imm);
	exp_ldu_req = predict_req(ldu_pick, exp_ldu);
	for (int i = 0; i < model_q.size(); i++) begin
		if ((i != alu_pick) && (i != ldu_pick)) begin
			e = model_q[i];
			e.A_ready = e.A_ready || operand_woken(e);
			kept.push_back(e);
		end
	end
	for (int w = 0; w < DISPATCH_WAYS; w++) begin
		if (exp_ack[w]) begin
			kept.push_back(seen_dispatch[w]);
		end
	end
	model_q = kept;
endtask

task automatic capture_inputs();
	seen_attempt = next_dispatch_attempt_by_way;
	seen_dispatch = next_dispatch_by_way;
	seen_alu_imm_ready = next_alu_imm_pipeline_ready;
	seen_ldu_ready = next_ldu_pipeline_ready;
	seen_wb = next_wb_bus_by_bank;
endtask

`endif

// ==== tests/tb_alu_imm_ldu_iq.sv ====
`timescale 1ns/1ps

// testbench for the ALU reg-imm / LDU issue queue wrapper
// directed phases then a random phase, outputs checked against a reference queue

module tb_alu_imm_ldu_iq;

	import core_types_pkg::*;
	import iq_types_pkg::*;

	localparam int IQ_ENTRIES = 8;
	localparam int WAIT_LIMIT = 80;
	localparam int RANDOM_CYCLES = 400;
	// attempt vectors of the fill phase, one nibble per cycle
	localparam logic [15:0] FILL_PATTERN = 16'hFB7F;

	logic CLK;
	logic nRST;
	logic [DISPATCH_WAYS-1:0] next_dispatch_attempt_by_way;
	iq_dispatch_t [DISPATCH_WAYS-1:0] next_dispatch_by_way;
	logic next_alu_imm_pipeline_ready;
	logic next_ldu_pipeline_ready;
	iq_wb_bus_t [PRF_BANK_COUNT-1:0] next_wb_bus_by_bank;
	logic [DISPATCH_WAYS-1:0] last_dispatch_ack_by_way;
	iq_issue_t last_issue_alu_imm;
	iq_issue_t last_issue_ldu;
	iq_prf_req_t last_prf_alu_imm_req;
	iq_prf_req_t last_prf_ldu_req;

	`include "tb_iq_model.svh"

	alu_imm_ldu_iq_wrapper #(
		.IQ_ENTRIES(IQ_ENTRIES)
	) dut (
		.CLK(CLK),
		.nRST(nRST),
		.next_dispatch_attempt_by_way(next_dispatch_attempt_by_way),
		.next_dispatch_by_way(next_dispatch_by_way),
		.next_alu_imm_pipeline_ready(next_alu_imm_pipeline_ready),
		.next_ldu_pipeline_ready(next_ldu_pipeline_ready),
		.next_wb_bus_by_bank(next_wb_bus_by_bank),
		.last_dispatch_ack_by_way(last_dispatch_ack_by_way),
		.last_issue_alu_imm(last_issue_alu_imm),
		.last_issue_ldu(last_issue_ldu),
		.last_prf_alu_imm_req(last_prf_alu_imm_req),
		.last_prf_ldu_req(last_prf_ldu_req)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			reset_model();
		end else begin
			step_model();
			capture_inputs();
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("ERROR at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
		$display("TEST RESULT: FAIL");
		$fatal(1, "output mismatch");
	endtask

	task automatic fail_timeout(input string what);
		$display("ERROR at %0t ns: timed out waiting for %s", $time, what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "wait timeout");
	endtask

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic clear_inputs();
		next_dispatch_attempt_by_way = '0;
		next_dispatch_by_way = '0;
		next_wb_bus_by_bank = '0;
	endtask

	function automatic iq_dispatch_t make_op(input logic to_ldu,
			input logic [LOG_PR_COUNT-1:0] A_PR, input logic A_ready, input logic A_is_zero);
		iq_dispatch_t d;
		logic [31:0] r;
		r = next_random();
		d.valid_alu_imm = !to_ldu;
		d.valid_ldu = to_ldu;
		d.op = r[3:0];
		d.imm12 = r[15:4];
		d.A_PR = A_PR;
		d.A_ready = A_ready;
		d.A_is_zero = A_is_zero;
		d.dest_PR = r[22:16];
		d.ROB_index = r[29:23];
		return d;
	endfunction

	task automatic offer(input int w, input iq_dispatch_t d);
		next_dispatch_attempt_by_way[w] = 1'b1;
		next_dispatch_by_way[w] = d;
	endtask

	task automatic wake(input logic [LOG_PR_COUNT-1:0] tag);
		next_wb_bus_by_bank[tag[LOG_PRF_BANK_COUNT-1:0]].valid = 1'b1;
		next_wb_bus_by_bank[tag[LOG_PRF_BANK_COUNT-1:0]].upper_PR =
			tag[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
	endtask

	task automatic wait_for_ack();
		for (int n = 0; n < WAIT_LIMIT; n++) begin
			next_cycle();
			if (last_dispatch_ack_by_way != '0) begin
				return;
			end
		end
		fail_timeout("a dispatch ack");
	endtask

	task automatic wait_for_issue(input logic to_ldu);
		for (int n = 0; n < WAIT_LIMIT; n++) begin
			next_cycle();
			if (to_ldu ? last_issue_ldu.valid : last_issue_alu_imm.valid) begin
				return;
			end
		end
		if (to_ldu) begin
			fail_timeout("an LDU issue");
		end else begin
			fail_timeout("an ALU reg-imm issue");
		end
	endtask

	// sweep every upper tag on all banks so nothing stays asleep
	task automatic drain_queue();
		clear_inputs();
		next_alu_imm_pipeline_ready = 1'b1;
		next_ldu_pipeline_ready = 1'b1;
		for (int n = 0; n < WAIT_LIMIT; n++) begin
			for (int b = 0; b < PRF_BANK_COUNT; b++) begin
				next_wb_bus_by_bank[b].valid = 1'b1;
				next_wb_bus_by_bank[b].upper_PR = n[LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0];
			end
			next_cycle();
			if ((model_q.size() == 0) && (seen_attempt == '0)) begin
				clear_inputs();
				return;
			end
		end
		fail_timeout("the queue to drain");
	endtask

	// ----------------------------------------
	// checks against the reference queue
	// ----------------------------------------

	assert property (@(negedge CLK) disable iff (!nRST)
		last_dispatch_ack_by_way == exp_ack)
		else report_mismatch("last_dispatch_ack_by_way", 64'(exp_ack),
			64'(last_dispatch_ack_by_way));

	assert property (@(negedge CLK) disable iff (!nRST)
		last_issue_alu_imm.valid == exp_alu_imm.valid)
		else report_mismatch("last_issue_alu_imm.valid", 64'(exp_alu_imm.valid),
			64'(last_issue_alu_imm.valid));

	assert property (@(negedge CLK) disable iff (!nRST)
		exp_alu_imm.valid |-> (last_issue_alu_imm == exp_alu_imm))
		else report_mismatch("last_issue_alu_imm", 64'(exp_alu_imm), 64'(last_issue_alu_imm));

	assert property (@(negedge CLK) disable iff (!nRST)
		last_issue_ldu.valid == exp_ldu.valid)
		else report_mismatch("last_issue_ldu.valid", 64'(exp_ldu.valid),
			64'(last_issue_ldu.valid));

	assert property (@(negedge CLK) disable iff (!nRST)
		exp_ldu.valid |-> (last_issue_ldu == exp_ldu))
		else report_mismatch("last_issue_ldu", 64'(exp_ldu), 64'(last_issue_ldu));

	// register reads
	assert property (@(negedge CLK) disable iff (!nRST)
		last_prf_alu_imm_req.valid == exp_alu_imm_req.valid)
		else report_mismatch("last_prf_alu_imm_req.valid", 64'(exp_alu_imm_req.valid),
			64'(last_prf_alu_imm_req.valid));

	assert property (@(negedge CLK) disable iff (!nRST)
		exp_alu_imm_req.valid |-> (last_prf_alu_imm_req == exp_alu_imm_req))
		else report_mismatch("last_prf_alu_imm_req", 64'(exp_alu_imm_req),
			64'(last_prf_alu_imm_req));

	assert property (@(negedge CLK) disable iff (!nRST)
		last_prf_ldu_req.valid == exp_ldu_req.valid)
		else report_mismatch("last_prf_ldu_req.valid", 64'(exp_ldu_req.valid),
			64'(last_prf_ldu_req.valid));

	assert property (@(negedge CLK) disable iff (!nRST)
		exp_ldu_req.valid |-> (last_prf_ldu_req == exp_ldu_req))
		else report_mismatch("last_prf_ldu_req", 64'(exp_ldu_req), 64'(last_prf_ldu_req));

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	initial begin
		logic [31:0] r;
		int tag_count;
		nRST = 1'b0;
		clear_inputs();
		next_alu_imm_pipeline_ready = 1'b0;
		next_ldu_pipeline_ready = 1'b0;
		for (int n = 0; n < 4; n++) begin
			next_cycle();
		end
		nRST = 1'b1;

		// idle after reset, all outputs quiet
		next_alu_imm_pipeline_ready = 1'b1;
		next_ldu_pipeline_ready = 1'b1;
		for (int n = 0; n < 5; n++) begin
			next_cycle();
		end

		// fill with sleeping operands, the last two cycles hit the free limit
		tag_count = 0;
		for (int c = 0; c < 4; c++) begin
			for (int w = 0; w < DISPATCH_WAYS; w++) begin
				if (FILL_PATTERN[c*4+w]) begin
					offer(w, make_op(tag_count[0], LOG_PR_COUNT'(16 + tag_count), 1'b0, 1'b0));
					tag_count++;
				end
			end
			next_cycle();
			clear_inputs();
		end
		for (int n = 0; n < 3; n++) begin
			next_cycle();
		end

		// writeback wakes one queued op per pipeline, issued with forward
		wake(7'h14);
		next_cycle();
		clear_inputs();
		wait_for_issue(1'b0);
		wake(7'h17);
		next_cycle();
		clear_inputs();
		wait_for_issue(1'b1);
		drain_queue();

		// ready ops on an empty queue, one with a zero operand
		offer(0, make_op(1'b0, 7'h21, 1'b1, 1'b0));
		offer(1, make_op(1'b1, 7'h22, 1'b1, 1'b0));
		offer(2, make_op(1'b0, 7'h00, 1'b0, 1'b1));
		offer(3, make_op(1'b1, 7'h23, 1'b1, 1'b0));
		next_cycle();
		clear_inputs();
		wait_for_ack();
		wait_for_issue(1'b0);
		drain_queue();

		// LDU held back while the ALU side keeps going
		next_ldu_pipeline_ready = 1'b0;
		for (int c = 0; c < 2; c++) begin
			for (int w = 0; w < DISPATCH_WAYS; w++) begin
				offer(w, make_op(w[0], LOG_PR_COUNT'(64 + c*4 + w), 1'b1, 1'b0));
			end
			next_cycle();
			clear_inputs();
		end
		for (int n = 0; n < 6; n++) begin
			next_cycle();
		end
		drain_queue();

		// random traffic, narrow tag range so writebacks hit often
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			r = next_random();
			next_alu_imm_pipeline_ready = (r[1:0] != 2'b00);
			next_ldu_pipeline_ready = (r[3:2] != 2'b00);
			for (int w = 0; w < DISPATCH_WAYS; w++) begin
				r = next_random();
				next_dispatch_attempt_by_way[w] = r[0];
				next_dispatch_by_way[w] = make_op(r[1], {3'b000, r[5:2]},
					r[7:6] == 2'b00, r[10:8] == 3'b000);
			end
			for (int b = 0; b < PRF_BANK_COUNT; b++) begin
				r = next_random();
				next_wb_bus_by_bank[b].valid = r[0];
				next_wb_bus_by_bank[b].upper_PR = {3'b000, r[2:1]};
			end
			next_cycle();
		end
		drain_queue();
		for (int n = 0; n < 3; n++) begin
			next_cycle();
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
